// File: Makefile
TOP = commit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f filelist.f -o commit_sim
	./obj_dir/commit_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
hw/commit_pkg.sv
hw/wb_stage.sv
hw/csr_file.sv
hw/reg_file.sv
hw/commit_top.sv
testbench/commit_tb.sv

// File: hw/commit_pkg.sv
package commit_pkg;

    typedef logic [31:0] word_t;         // data, pc and address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [5:0]  excep_flags_t;  // one-hot by convention

    // flag bit positions, int in the msb down to ale in the lsb
    localparam int EXC_INT  = 5;
    localparam int EXC_ADEF = 4;
    localparam int EXC_SYS  = 3;
    localparam int EXC_BRK  = 2;
    localparam int EXC_INE  = 1;
    localparam int EXC_ALE  = 0;

    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_TID    = 14'h40;

    localparam ecode_t ECODE_INT  = 6'h0;
    localparam ecode_t ECODE_ADEF = 6'h8;
    localparam ecode_t ECODE_ALE  = 6'h9;
    localparam ecode_t ECODE_SYS  = 6'hb;
    localparam ecode_t ECODE_BRK  = 6'hc;
    localparam ecode_t ECODE_INE  = 6'hd;

endpackage

// File: hw/commit_top.sv
`timescale 1ns/1ps

module commit_top #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c00_8000
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     mem_valid,
    input  commit_pkg::word_t        mem_pc,
    input  logic                     mem_rf_we,
    input  commit_pkg::reg_addr_t    mem_rf_waddr,
    input  commit_pkg::word_t        mem_rf_wdata,
    input  logic                     mem_csr_re,
    input  logic                     mem_csr_we,
    input  commit_pkg::csr_num_t     mem_csr_num,
    input  commit_pkg::word_t        mem_csr_wmask,
    input  commit_pkg::word_t        mem_csr_wvalue,
    input  logic                     mem_read_tid,
    input  logic                     mem_ertn,
    input  commit_pkg::excep_flags_t mem_excep,
    input  commit_pkg::esubcode_t    mem_esubcode,
    input  commit_pkg::word_t        mem_vaddr,
    output logic                     wb_allowin,
    input  commit_pkg::reg_addr_t    rd_addr0,
    input  commit_pkg::reg_addr_t    rd_addr1,
    output commit_pkg::word_t        rd_data0,
    output commit_pkg::word_t        rd_data1,
    output logic                     flush_valid,
    output commit_pkg::word_t        flush_target,
    output commit_pkg::word_t        debug_wb_pc,
    output logic [3:0]               debug_wb_rf_we,
    output commit_pkg::reg_addr_t    debug_wb_rf_wnum,
    output commit_pkg::word_t        debug_wb_rf_wdata
);

    // wb_stage to csr_file
    logic                  csr_re;
    commit_pkg::csr_num_t  csr_num;
    logic                  csr_we;
    commit_pkg::word_t     csr_wmask;
    commit_pkg::word_t     csr_wvalue;
    commit_pkg::word_t     csr_rvalue;
    logic                  wb_ex;
    commit_pkg::ecode_t    wb_ecode;
    commit_pkg::esubcode_t wb_esubcode;
    commit_pkg::word_t     wb_ex_pc;
    commit_pkg::word_t     wb_vaddr;
    logic                  ertn_flush;

    // wb_stage to reg_file
    logic                  rf_we;
    commit_pkg::reg_addr_t rf_waddr;
    commit_pkg::word_t     rf_wdata;

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mem_valid         (mem_valid),
        .wb_allowin        (wb_allowin),
        .mem_pc            (mem_pc),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_wdata      (mem_rf_wdata),
        .mem_csr_re        (mem_csr_re),
        .mem_csr_we        (mem_csr_we),
        .mem_csr_num       (mem_csr_num),
        .mem_csr_wmask     (mem_csr_wmask),
        .mem_csr_wvalue    (mem_csr_wvalue),
        .mem_read_tid      (mem_read_tid),
        .mem_ertn          (mem_ertn),
        .mem_excep         (mem_excep),
        .mem_esubcode      (mem_esubcode),
        .mem_vaddr         (mem_vaddr),
        .csr_re            (csr_re),
        .csr_num           (csr_num),
        .csr_we            (csr_we),
        .csr_wmask         (csr_wmask),
        .csr_wvalue        (csr_wvalue),
        .csr_rvalue        (csr_rvalue),
        .wb_ex             (wb_ex),
        .wb_ecode          (wb_ecode),
        .wb_esubcode       (wb_esubcode),
        .wb_ex_pc          (wb_ex_pc),
        .wb_vaddr          (wb_vaddr),
        .ertn_flush        (ertn_flush),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .flush_valid       (flush_valid),
        .flush_target      (flush_target),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file #(
        .EENTRY_RESET (EENTRY_RESET)
    ) u_csr_file (
        .clk         (clk),
        .resetn      (resetn),
        .re          (csr_re),
        .num         (csr_num),
        .we          (csr_we),
        .wmask       (csr_wmask),
        .wvalue      (csr_wvalue),
        .rvalue      (csr_rvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_ex_pc    (wb_ex_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr0 (rd_addr0),
        .raddr1 (rd_addr1),
        .rdata0 (rd_data0),
        .rdata1 (rd_data1)
    );

endmodule

// File: hw/csr_file.sv
`timescale 1ns/1ps

module csr_file #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c00_8000
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  re,
    input  commit_pkg::csr_num_t  num,
    input  logic                  we,
    input  commit_pkg::word_t     wmask,
    input  commit_pkg::word_t     wvalue,
    output commit_pkg::word_t     rvalue,
    input  logic                  wb_ex,
    input  commit_pkg::ecode_t    wb_ecode,
    input  commit_pkg::esubcode_t wb_esubcode,
    input  commit_pkg::word_t     wb_ex_pc,
    input  commit_pkg::word_t     wb_vaddr,
    input  logic                  ertn_flush
);

    // crmd / prmd fields
    logic [1:0] crmd_plv;
    logic       crmd_ie;
    logic [1:0] prmd_pplv;
    logic       prmd_pie;

    // estat, hardware written only
    commit_pkg::ecode_t    estat_ecode;
    commit_pkg::esubcode_t estat_esubcode;

    logic [25:0]       eentry_va;   // entry is 64-byte aligned
    commit_pkg::word_t era;
    commit_pkg::word_t badv;
    commit_pkg::word_t save0;
    commit_pkg::word_t tid;

    commit_pkg::word_t csr_rd;      // selected register, before re
    commit_pkg::word_t wmerged;

    function automatic commit_pkg::word_t merge(
        input commit_pkg::word_t old_v,
        input commit_pkg::word_t mask,
        input commit_pkg::word_t val
    );
        merge = (old_v & ~mask) | (val & mask);
    endfunction

    always_comb begin
        case (num)
            commit_pkg::CSR_CRMD:   csr_rd = {29'b0, crmd_ie, crmd_plv};
            commit_pkg::CSR_PRMD:   csr_rd = {29'b0, prmd_pie, prmd_pplv};
            commit_pkg::CSR_ESTAT:  csr_rd = {1'b0, estat_esubcode, estat_ecode, 16'b0};
            commit_pkg::CSR_ERA:    csr_rd = era;
            commit_pkg::CSR_BADV:   csr_rd = badv;
            commit_pkg::CSR_EENTRY: csr_rd = {eentry_va, 6'b0};
            commit_pkg::CSR_SAVE0:  csr_rd = save0;
            commit_pkg::CSR_TID:    csr_rd = tid;
            default:                csr_rd = '0;  // unimplemented reads zero
        endcase
    end

    assign rvalue  = re ? csr_rd : '0;
    assign wmerged = merge(csr_rd, wmask, wvalue);  // bits outside the mask keep old value

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv       <= 2'b0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            eentry_va      <= EENTRY_RESET[31:6];
            tid            <= '0;
        end else if (wb_ex) begin
            prmd_pplv      <= crmd_plv;    // save current mode
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'b0;        // enter kernel, interrupts off
            crmd_ie        <= 1'b0;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (we) begin
            case (num)
                commit_pkg::CSR_CRMD: begin
                    crmd_plv <= wmerged[1:0];
                    crmd_ie  <= wmerged[2];
                end
                commit_pkg::CSR_PRMD: begin
                    prmd_pplv <= wmerged[1:0];
                    prmd_pie  <= wmerged[2];
                end
                commit_pkg::CSR_EENTRY: eentry_va <= wmerged[31:6];
                commit_pkg::CSR_TID:    tid       <= wmerged;
                default: ;
            endcase
        end
    end

    // era, badv, save0 carry data only
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            era <= wb_ex_pc;
            if (wb_ecode == commit_pkg::ECODE_ADEF) begin
                badv <= wb_ex_pc;       // fetch address that faulted
            end else if (wb_ecode == commit_pkg::ECODE_ALE) begin
                badv <= wb_vaddr;
            end
        end else if (we && !ertn_flush) begin
            case (num)
                commit_pkg::CSR_ERA:   era   <= wmerged;
                commit_pkg::CSR_BADV:  badv  <= wmerged;
                commit_pkg::CSR_SAVE0: save0 <= wmerged;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  we,
    input  commit_pkg::reg_addr_t waddr,
    input  commit_pkg::word_t     wdata,
    input  commit_pkg::reg_addr_t raddr0,
    input  commit_pkg::reg_addr_t raddr1,
    output commit_pkg::word_t     rdata0,
    output commit_pkg::word_t     rdata1
);

    commit_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async read, r0 hardwired
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     mem_valid,
    output logic                     wb_allowin,
    input  commit_pkg::word_t        mem_pc,
    input  logic                     mem_rf_we,
    input  commit_pkg::reg_addr_t    mem_rf_waddr,
    input  commit_pkg::word_t        mem_rf_wdata,
    input  logic                     mem_csr_re,
    input  logic                     mem_csr_we,
    input  commit_pkg::csr_num_t     mem_csr_num,
    input  commit_pkg::word_t        mem_csr_wmask,
    input  commit_pkg::word_t        mem_csr_wvalue,
    input  logic                     mem_read_tid,
    input  logic                     mem_ertn,
    input  commit_pkg::excep_flags_t mem_excep,
    input  commit_pkg::esubcode_t    mem_esubcode,
    input  commit_pkg::word_t        mem_vaddr,
    output logic                     csr_re,
    output commit_pkg::csr_num_t     csr_num,
    output logic                     csr_we,
    output commit_pkg::word_t        csr_wmask,
    output commit_pkg::word_t        csr_wvalue,
    input  commit_pkg::word_t        csr_rvalue,
    output logic                     wb_ex,
    output commit_pkg::ecode_t       wb_ecode,
    output commit_pkg::esubcode_t    wb_esubcode,
    output commit_pkg::word_t        wb_ex_pc,
    output commit_pkg::word_t        wb_vaddr,
    output logic                     ertn_flush,
    output logic                     rf_we,
    output commit_pkg::reg_addr_t    rf_waddr,
    output commit_pkg::word_t        rf_wdata,
    output logic                     flush_valid,
    output commit_pkg::word_t        flush_target,
    output commit_pkg::word_t        debug_wb_pc,
    output logic [3:0]               debug_wb_rf_we,
    output commit_pkg::reg_addr_t    debug_wb_rf_wnum,
    output commit_pkg::word_t        debug_wb_rf_wdata
);

    logic ready_go;
    logic wb_valid;

    // held instruction
    commit_pkg::word_t        pc_q;
    logic                     rf_we_q;
    commit_pkg::reg_addr_t    rf_waddr_q;
    commit_pkg::word_t        rf_wdata_q;
    logic                     csr_re_q;
    logic                     csr_we_q;
    commit_pkg::csr_num_t     csr_num_q;
    commit_pkg::word_t        csr_wmask_q;
    commit_pkg::word_t        csr_wvalue_q;
    logic                     read_tid_q;
    logic                     ertn_q;
    commit_pkg::excep_flags_t excep_q;
    commit_pkg::esubcode_t    esubcode_q;
    commit_pkg::word_t        vaddr_q;

    assign ready_go   = 1'b1;   // single-cycle commit
    assign wb_allowin = ~wb_valid | ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush_valid) begin
            wb_valid <= 1'b0;   // flushing instruction leaves, nothing enters
        end else if (wb_allowin) begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allowin) begin
            pc_q         <= mem_pc;
            rf_we_q      <= mem_rf_we;
            rf_waddr_q   <= mem_rf_waddr;
            rf_wdata_q   <= mem_rf_wdata;
            csr_re_q     <= mem_csr_re;
            csr_we_q     <= mem_csr_we;
            csr_num_q    <= mem_csr_num;
            csr_wmask_q  <= mem_csr_wmask;
            csr_wvalue_q <= mem_csr_wvalue;
            read_tid_q   <= mem_read_tid;
            ertn_q       <= mem_ertn;
            excep_q      <= mem_excep;
            esubcode_q   <= mem_esubcode;
            vaddr_q      <= mem_vaddr;
        end
    end

    assign wb_ex      = wb_valid & (|excep_q);
    assign ertn_flush = wb_valid & ertn_q & ~wb_ex;

    // fixed priority, int highest
    always_comb begin
        if (excep_q[commit_pkg::EXC_INT])       wb_ecode = commit_pkg::ECODE_INT;
        else if (excep_q[commit_pkg::EXC_ADEF]) wb_ecode = commit_pkg::ECODE_ADEF;
        else if (excep_q[commit_pkg::EXC_SYS])  wb_ecode = commit_pkg::ECODE_SYS;
        else if (excep_q[commit_pkg::EXC_BRK])  wb_ecode = commit_pkg::ECODE_BRK;
        else if (excep_q[commit_pkg::EXC_INE])  wb_ecode = commit_pkg::ECODE_INE;
        else                                    wb_ecode = commit_pkg::ECODE_ALE;
    end

    assign wb_esubcode = esubcode_q;
    assign wb_ex_pc    = pc_q;
    assign wb_vaddr    = vaddr_q;

    // read port is borrowed for the redirect address
    assign csr_num = wb_ex      ? commit_pkg::CSR_EENTRY :
                     ertn_flush ? commit_pkg::CSR_ERA :
                     read_tid_q ? commit_pkg::CSR_TID : csr_num_q;
    assign csr_re     = (wb_valid & (csr_re_q | read_tid_q)) | wb_ex | ertn_flush;
    assign csr_we     = wb_valid & csr_we_q & ~wb_ex;
    assign csr_wmask  = csr_wmask_q;
    assign csr_wvalue = csr_wvalue_q;

    assign rf_we    = wb_valid & rf_we_q & ~wb_ex;
    assign rf_waddr = rf_waddr_q;
    assign rf_wdata = (csr_re_q | read_tid_q) ? csr_rvalue : rf_wdata_q;

    assign flush_valid  = wb_ex | ertn_flush;
    assign flush_target = flush_valid ? csr_rvalue : '0;

    assign debug_wb_pc       = pc_q;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr_q;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: testbench/commit_golden.mem
// pc_ctl_rd_wdata_csr_wmask_wvalue_excep_esub_vaddr_expwe_expwnum_expwdata_expflush_target
// ctl bits: 10 rf_we, 08 csr_re, 04 csr_we, 02 read_tid, 01 ertn
1c000000_10_01_12345678_0000_00000000_00000000_00_000_00000000_f_01_12345678_0_00000000
1c000004_10_02_deadbeef_0000_00000000_00000000_00_000_00000000_f_02_deadbeef_0_00000000
1c000008_10_00_cafef00d_0000_00000000_00000000_00_000_00000000_f_00_cafef00d_0_00000000
1c00000c_04_00_00000000_0030_ffffffff_a5a5a5a5_00_000_00000000_0_00_00000000_0_00000000
1c000010_1c_04_00000000_0030_0000ffff_12343c3c_00_000_00000000_f_04_a5a5a5a5_0_00000000
1c000014_18_05_00000000_0030_00000000_00000000_00_000_00000000_f_05_a5a53c3c_0_00000000
1c000018_1c_06_00000000_0000_ffffffff_00000007_00_000_00000000_f_06_00000000_0_00000000
1c00001c_10_07_11111111_0000_00000000_00000000_08_000_00000000_0_00_00000000_1_1c008000
1c008000_18_08_00000000_0006_00000000_00000000_00_000_00000000_f_08_1c00001c_0_00000000
1c008004_18_09_00000000_0005_00000000_00000000_00_000_00000000_f_09_000b0000_0_00000000
1c008008_18_0a_00000000_0000_00000000_00000000_00_000_00000000_f_0a_00000000_0_00000000
1c00800c_18_0b_00000000_0001_00000000_00000000_00_000_00000000_f_0b_00000007_0_00000000
1c008010_01_00_00000000_0000_00000000_00000000_00_000_00000000_0_00_00000000_1_1c00001c
1c000020_18_0c_00000000_0000_00000000_00000000_00_000_00000000_f_0c_00000007_0_00000000
1c000024_12_0d_00000000_0000_00000000_00000000_00_000_00000000_f_0d_00000000_0_00000000
1c000029_00_00_00000000_0000_00000000_00000000_10_000_00000000_0_00_00000000_1_1c008000
1c008000_18_0e_00000000_0005_00000000_00000000_00_000_00000000_f_0e_00080000_0_00000000
1c008004_18_0f_00000000_0007_00000000_00000000_00_000_00000000_f_0f_1c000029_0_00000000
1c008008_10_10_00000000_0000_00000000_00000000_01_000_00001003_0_00_00000000_1_1c008000
1c008000_18_11_00000000_0005_00000000_00000000_00_000_00000000_f_11_00090000_0_00000000
1c008004_18_12_00000000_0007_00000000_00000000_00_000_00000000_f_12_00001003_0_00000000
1c008008_00_00_00000000_0000_00000000_00000000_04_000_00000000_0_00_00000000_1_1c008000
1c008000_18_13_00000000_0005_00000000_00000000_00_000_00000000_f_13_000c0000_0_00000000
1c008004_00_00_00000000_0000_00000000_00000000_02_001_00000000_0_00_00000000_1_1c008000
1c008000_18_14_00000000_0005_00000000_00000000_00_000_00000000_f_14_004d0000_0_00000000
1c008004_00_00_00000000_0000_00000000_00000000_0c_000_00000000_0_00_00000000_1_1c008000
1c008000_18_15_00000000_0005_00000000_00000000_00_000_00000000_f_15_000b0000_0_00000000
1c008002_00_00_00000000_0000_00000000_00000000_11_000_0000beef_0_00_00000000_1_1c008000
1c008000_18_16_00000000_0005_00000000_00000000_00_000_00000000_f_16_00080000_0_00000000
1c008004_18_17_00000000_0007_00000000_00000000_00_000_00000000_f_17_1c008002_0_00000000

// File: testbench/commit_tb.sv
`timescale 1ns/1ps

module commit_tb;

    localparam int NUM_VECTORS = 30;
    localparam int WAIT_LIMIT  = 20;   // cycles to wait for wb_allowin

    // one golden line with nibble aligned fields, see commit_golden.mem
    typedef logic [291:0] golden_t;

    golden_t golden [0:NUM_VECTORS-1];

    logic clk = 1'b0;
    logic resetn;

    logic                     mem_valid;
    commit_pkg::word_t        mem_pc;
    logic                     mem_rf_we;
    commit_pkg::reg_addr_t    mem_rf_waddr;
    commit_pkg::word_t        mem_rf_wdata;
    logic                     mem_csr_re;
    logic                     mem_csr_we;
    commit_pkg::csr_num_t     mem_csr_num;
    commit_pkg::word_t        mem_csr_wmask;
    commit_pkg::word_t        mem_csr_wvalue;
    logic                     mem_read_tid;
    logic                     mem_ertn;
    commit_pkg::excep_flags_t mem_excep;
    commit_pkg::esubcode_t    mem_esubcode;
    commit_pkg::word_t        mem_vaddr;
    logic                     wb_allowin;
    commit_pkg::reg_addr_t    rd_addr0;
    commit_pkg::reg_addr_t    rd_addr1;
    commit_pkg::word_t        rd_data0;
    commit_pkg::word_t        rd_data1;
    logic                     flush_valid;
    commit_pkg::word_t        flush_target;
    commit_pkg::word_t        debug_wb_pc;
    logic [3:0]               debug_wb_rf_we;
    commit_pkg::reg_addr_t    debug_wb_rf_wnum;
    commit_pkg::word_t        debug_wb_rf_wdata;

    commit_pkg::word_t     shadow [32];       // expected register contents
    commit_pkg::reg_addr_t prev_wnum = '0;    // last nonzero register written

    int   checks    = 0;
    int   errors    = 0;
    int   vec_idx   = 0;
    logic timed_out = 1'b0;

    always #4 clk = ~clk;   // 8 ns period

    commit_top #(
        .EENTRY_RESET (32'h1c00_8000)
    ) DUT (
        .clk (clk), .resetn (resetn),
        .mem_valid (mem_valid), .mem_pc (mem_pc),
        .mem_rf_we (mem_rf_we), .mem_rf_waddr (mem_rf_waddr), .mem_rf_wdata (mem_rf_wdata),
        .mem_csr_re (mem_csr_re), .mem_csr_we (mem_csr_we), .mem_csr_num (mem_csr_num),
        .mem_csr_wmask (mem_csr_wmask), .mem_csr_wvalue (mem_csr_wvalue),
        .mem_read_tid (mem_read_tid), .mem_ertn (mem_ertn),
        .mem_excep (mem_excep), .mem_esubcode (mem_esubcode), .mem_vaddr (mem_vaddr),
        .wb_allowin (wb_allowin),
        .rd_addr0 (rd_addr0), .rd_addr1 (rd_addr1),
        .rd_data0 (rd_data0), .rd_data1 (rd_data1),
        .flush_valid (flush_valid), .flush_target (flush_target),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_we (debug_wb_rf_we),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic check_word(input commit_pkg::word_t got, input commit_pkg::word_t exp,
                              input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %08h expected %08h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic check_reg(input commit_pkg::reg_addr_t got,
                             input commit_pkg::reg_addr_t exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %02h expected %02h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %01h expected %01h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    task automatic check_we(input logic [3:0] got, input logic [3:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %01h expected %01h at vector %0d", name, got, exp, vec_idx);
        end
    endtask

    // send one instruction and check its trace, flush and register readback
    task automatic run_vector(input golden_t v);
        int waited;
        waited = 0;
        @(posedge clk);
        mem_valid      <= 1'b1;
        mem_pc         <= v[291:260];
        mem_rf_we      <= v[256];
        mem_csr_re     <= v[255];
        mem_csr_we     <= v[254];
        mem_read_tid   <= v[253];
        mem_ertn       <= v[252];
        mem_rf_waddr   <= v[248:244];
        mem_rf_wdata   <= v[243:212];
        mem_csr_num    <= v[209:196];
        mem_csr_wmask  <= v[195:164];
        mem_csr_wvalue <= v[163:132];
        mem_excep      <= v[129:124];
        mem_esubcode   <= v[120:112];
        mem_vaddr      <= v[111:80];
        @(negedge clk);
        while (!wb_allowin && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_allowin) begin
            timed_out = 1'b1;
            errors++;
        end else begin
            @(posedge clk);   // transfer edge
            mem_valid <= 1'b0;
            @(negedge clk);   // instruction held in wb
            check_word(debug_wb_pc, v[291:260], "debug_wb_pc");
            check_we(debug_wb_rf_we, v[79:76], "debug_wb_rf_we");
            if (v[79:76] != 4'h0) begin
                check_reg(debug_wb_rf_wnum, v[72:68], "debug_wb_rf_wnum");
                check_word(debug_wb_rf_wdata, v[67:36], "debug_wb_rf_wdata");
            end
            check_flag(flush_valid, v[32], "flush_valid");
            if (v[32]) begin
                check_word(flush_target, v[31:0], "flush_target");
            end
            @(posedge clk);   // commit edge
            rd_addr0 <= v[72:68];
            rd_addr1 <= prev_wnum;   // an older register on the second port
            @(negedge clk);
            if (v[79:76] != 4'h0) begin
                if (v[72:68] != 5'd0) begin
                    shadow[v[72:68]] = v[67:36];
                end
                check_word(rd_data0, shadow[v[72:68]], "rd_data0");
                check_word(rd_data1, shadow[prev_wnum], "rd_data1");
                if (v[72:68] != 5'd0) begin
                    prev_wnum = v[72:68];
                end
            end
            check_flag(flush_valid, 1'b0, "flush_valid after commit");
            if (v[32]) begin
                @(posedge clk);   // bubble behind the flush
            end
        end
    endtask

    initial begin
        int i;
        resetn         <= 1'b0;
        mem_valid      <= 1'b0;
        mem_pc         <= '0;
        mem_rf_we      <= 1'b0;
        mem_rf_waddr   <= '0;
        mem_rf_wdata   <= '0;
        mem_csr_re     <= 1'b0;
        mem_csr_we     <= 1'b0;
        mem_csr_num    <= '0;
        mem_csr_wmask  <= '0;
        mem_csr_wvalue <= '0;
        mem_read_tid   <= 1'b0;
        mem_ertn       <= 1'b0;
        mem_excep      <= '0;
        mem_esubcode   <= '0;
        mem_vaddr      <= '0;
        rd_addr0       <= '0;
        rd_addr1       <= '0;
        for (i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        $readmemh("testbench/commit_golden.mem", golden);
        if ($isunknown(golden[NUM_VECTORS-1]) || golden[NUM_VECTORS-1][291:260] == 32'h0) begin
            errors++;
            $display("golden file holds fewer than %0d vectors", NUM_VECTORS);
        end
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_flag(flush_valid, 1'b0, "flush_valid");
        check_we(debug_wb_rf_we, 4'h0, "debug_wb_rf_we");
        for (i = 0; i < NUM_VECTORS && !timed_out; i++) begin
            vec_idx = i;
            run_vector(golden[i]);
        end
        if (timed_out) begin
            $display("timeout, wb_allowin stayed low at vector %0d", vec_idx);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
